// ==== rtl/mldsa_params_pkg.sv ====
/* ML-DSA modulus, polynomial size, eta and coefficient types */
`default_nettype none

package mldsa_params_pkg;

  // modulus q = 2^23 - 2^13 + 1
  localparam int unsigned MLDSA_Q_W = 23;
  localparam logic [MLDSA_Q_W-1:0] MLDSA_Q = 23'd8380417;

  // polynomial size and lanes per cycle
  localparam int unsigned MLDSA_N = 256;
  localparam int unsigned COEFF_PER_CLK = 4;
  localparam int unsigned MLDSA_COEFF_CYCLES = MLDSA_N / COEFF_PER_CLK;

  localparam int unsigned MLDSA_ETA = 2;

  typedef logic [MLDSA_Q_W-1:0] coeff_t;
  typedef coeff_t [COEFF_PER_CLK-1:0] coeff_vec_t;

  // counts output cycles of one polynomial
  typedef logic [$clog2(MLDSA_COEFF_CYCLES)-1:0] coeff_cyc_t;

endpackage

`default_nettype wire

// ==== rtl/sampler_pkg.sv ====
/* sampler modes, sample widths, PISO rates and buffer depths,
   address, block, PISO and command types */
`default_nettype none

package sampler_pkg;

  // destination memory
  localparam int unsigned MEM_ADDR_W = 12;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

  // squeezed block as delivered by the source
  localparam int unsigned BLOCK_W = 96;
  typedef logic [BLOCK_W-1:0] block_t;

  // uniform sampler, four 24-bit samples per cycle
  localparam int unsigned REJS_SAMPLE_W = 24;
  localparam int unsigned REJS_NUM_SAMPLERS = 4;
  localparam int unsigned REJS_PISO_OUTPUT_RATE = REJS_SAMPLE_W * REJS_NUM_SAMPLERS;
  localparam int unsigned REJS_BUF_DEPTH = 7;
  typedef logic [$clog2(REJS_BUF_DEPTH+1)-1:0] rejs_cnt_t;

  // bounded sampler, eight nibbles per cycle
  localparam int unsigned REJB_SAMPLE_W = 4;
  localparam int unsigned REJB_NUM_SAMPLERS = 8;
  localparam logic [REJB_SAMPLE_W-1:0] REJB_VALUE = 4'd15;
  localparam int unsigned REJB_PISO_OUTPUT_RATE = REJB_SAMPLE_W * REJB_NUM_SAMPLERS;
  localparam int unsigned REJB_BUF_DEPTH = 12;
  localparam int unsigned REJB_HOLD_LEVEL = 8;
  typedef logic [$clog2(REJB_BUF_DEPTH+1)-1:0] rejb_cnt_t;

  // PISO holds up to two blocks
  localparam int unsigned PISO_BUFFER_W = 2 * BLOCK_W;
  typedef logic [$clog2(PISO_BUFFER_W+1)-1:0] piso_fill_t;
  typedef logic [REJS_PISO_OUTPUT_RATE-1:0] piso_data_t;

  typedef enum logic {
    MODE_REJ_UNIFORM = 1'b0,
    MODE_REJ_BOUNDED = 1'b1
  } sampler_mode_e;

  typedef struct packed {
    sampler_mode_e mode;
    mem_addr_t     dest_base_addr;
  } sampler_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/sampler_ctrl.sv ====
/* command FSM with squeeze requests, coefficient cycle counter
   and destination address counter */
`default_nettype none

module sampler_ctrl (
  input  logic                      clk,
  input  logic                      rst_b,
  input  logic                      zeroize_i,
  input  logic                      start_i,
  input  sampler_pkg::sampler_cmd_t cmd_i,
  input  logic                      coeff_vld_i,
  input  logic                      block_taken_i,
  output logic                      squeeze_o,
  output logic                      busy_o,
  output logic                      clear_o,
  output sampler_pkg::mem_addr_t    dest_addr_o
);

  typedef enum logic [2:0] {
    IDLE,
    PROC,
    WAIT,
    RUN,
    DONE
  } ctrl_state_e;

  ctrl_state_e state_q, state_d;
  mldsa_params_pkg::coeff_cyc_t coeff_cnt_q;
  logic last_vld;

  // 64th output cycle of the polynomial
  assign last_vld = coeff_vld_i &
                    (coeff_cnt_q == mldsa_params_pkg::coeff_cyc_t'(
                                    mldsa_params_pkg::MLDSA_COEFF_CYCLES - 1));

  assign busy_o = start_i | (state_q != IDLE);

  // also held through DONE so a late block is dropped from the PISO
  assign clear_o = zeroize_i | last_vld | (state_q == DONE);

  always_comb begin
    state_d = state_q;
    squeeze_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = PROC;
        end
      end
      PROC: begin
        squeeze_o = 1'b1;
        state_d = WAIT;
      end
      WAIT: begin
        if (last_vld) begin
          state_d = DONE;
        end else if (block_taken_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (last_vld) begin
          state_d = DONE;
        end else begin
          // ask for the next block
          squeeze_o = 1'b1;
          state_d = WAIT;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= IDLE;
    end else if (zeroize_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // cycle count and address, loaded at start
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      coeff_cnt_q <= '0;
      dest_addr_o <= '0;
    end else if (clear_o) begin
      coeff_cnt_q <= '0;
      dest_addr_o <= '0;
    end else if (start_i) begin
      coeff_cnt_q <= '0;
      dest_addr_o <= cmd_i.dest_base_addr;
    end else if (coeff_vld_i) begin
      coeff_cnt_q <= coeff_cnt_q + 1'b1;
      dest_addr_o <= dest_addr_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sampler_piso.sv ====
/* block buffer, takes 96-bit blocks and hands out
   96-bit or 32-bit sample groups by mode */
`default_nettype none

module sampler_piso (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       clear_i,
  input  sampler_pkg::sampler_mode_e mode_i,
  input  logic                       valid_i,
  input  sampler_pkg::block_t        data_i,
  output logic                       hold_o,
  output logic                       valid_o,
  input  logic                       hold_i,
  output sampler_pkg::piso_data_t    data_o
);

  logic [sampler_pkg::PISO_BUFFER_W-1:0] shreg_q, shreg_d;
  logic [sampler_pkg::PISO_BUFFER_W-1:0] shifted, keep_mask, blk_ext;
  sampler_pkg::piso_fill_t fill_q, fill_d, fill_left, rate;
  logic take;

  assign rate = (mode_i == sampler_pkg::MODE_REJ_BOUNDED) ?
                sampler_pkg::piso_fill_t'(sampler_pkg::REJB_PISO_OUTPUT_RATE) :
                sampler_pkg::piso_fill_t'(sampler_pkg::REJS_PISO_OUTPUT_RATE);

  // no room for another block
  assign hold_o = fill_q > sampler_pkg::piso_fill_t'(sampler_pkg::PISO_BUFFER_W -
                                                     sampler_pkg::BLOCK_W);
  assign take = valid_i & ~hold_o;

  assign valid_o = ~hold_i & (fill_q >= rate);
  assign data_o = shreg_q[sampler_pkg::REJS_PISO_OUTPUT_RATE-1:0];

  assign blk_ext = {{(sampler_pkg::PISO_BUFFER_W - sampler_pkg::BLOCK_W){1'b0}}, data_i};

  always_comb begin
    shifted = valid_o ? (shreg_q >> rate) : shreg_q;
    fill_left = valid_o ? (fill_q - rate) : fill_q;
    // bits above the fill are stale
    keep_mask = '1;
    keep_mask = ~(keep_mask << fill_left);
    shreg_d = shifted & keep_mask;
    fill_d = fill_left;
    if (take) begin
      shreg_d = shreg_d | (blk_ext << fill_left);
      fill_d = fill_left + sampler_pkg::piso_fill_t'(sampler_pkg::BLOCK_W);
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fill_q <= '0;
    end else if (clear_i) begin
      fill_q <= '0;
    end else begin
      fill_q <= fill_d;
    end
  end

  always_ff @(posedge clk) begin
    if (clear_i) begin
      shreg_q <= '0;
    end else begin
      shreg_q <= shreg_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rej_sampler.sv ====
/* uniform rejection sampler, 23-bit samples kept below q,
   accept buffer emitting four coefficients at a time */
`default_nettype none

module rej_sampler (
  input  logic clk,
  input  logic rst_b,
  input  logic clear_i,
  input  logic valid_i,
  input  logic [sampler_pkg::REJS_NUM_SAMPLERS-1:0][sampler_pkg::REJS_SAMPLE_W-1:0] data_i,
  output logic valid_o,
  output mldsa_params_pkg::coeff_vec_t data_o
);

  mldsa_params_pkg::coeff_t acc_q [sampler_pkg::REJS_BUF_DEPTH];
  mldsa_params_pkg::coeff_t acc_d [sampler_pkg::REJS_BUF_DEPTH];
  sampler_pkg::rejs_cnt_t cnt_q, cnt_d;
  mldsa_params_pkg::coeff_vec_t out_d;
  logic pop;

  // four or more held, oldest four leave
  assign pop = cnt_q >= sampler_pkg::rejs_cnt_t'(mldsa_params_pkg::COEFF_PER_CLK);

  always_comb begin
    mldsa_params_pkg::coeff_t smp;
    acc_d = acc_q;
    cnt_d = cnt_q;
    smp = '0;
    for (int l = 0; l < mldsa_params_pkg::COEFF_PER_CLK; l++) begin
      out_d[l] = acc_q[l];
    end
    if (pop) begin
      for (int i = 0; i < sampler_pkg::REJS_BUF_DEPTH - mldsa_params_pkg::COEFF_PER_CLK; i++) begin
        acc_d[i] = acc_q[i + mldsa_params_pkg::COEFF_PER_CLK];
      end
      cnt_d = cnt_q - sampler_pkg::rejs_cnt_t'(mldsa_params_pkg::COEFF_PER_CLK);
    end
    // append accepted samples, lowest first
    if (valid_i) begin
      for (int s = 0; s < sampler_pkg::REJS_NUM_SAMPLERS; s++) begin
        smp = data_i[s][mldsa_params_pkg::MLDSA_Q_W-1:0];
        if (smp < mldsa_params_pkg::MLDSA_Q) begin
          acc_d[cnt_d] = smp;
          cnt_d = cnt_d + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q <= '0;
      valid_o <= 1'b0;
    end else if (clear_i) begin
      cnt_q <= '0;
      valid_o <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      valid_o <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (clear_i) begin
      acc_q <= '{default: '0};
      data_o <= '0;
    end else begin
      acc_q <= acc_d;
      if (pop) begin
        data_o <= out_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rej_bounded.sv ====
/* bounded rejection sampler for eta = 2, nibbles below 15
   mapped to 2 - (n mod 5) mod q, buffered and emitted by four */
`default_nettype none

module rej_bounded (
  input  logic clk,
  input  logic rst_b,
  input  logic clear_i,
  input  logic valid_i,
  input  logic [sampler_pkg::REJB_NUM_SAMPLERS-1:0][sampler_pkg::REJB_SAMPLE_W-1:0] data_i,
  output logic hold_o,
  output logic valid_o,
  output mldsa_params_pkg::coeff_vec_t data_o
);

  mldsa_params_pkg::coeff_t acc_q [sampler_pkg::REJB_BUF_DEPTH];
  mldsa_params_pkg::coeff_t acc_d [sampler_pkg::REJB_BUF_DEPTH];
  sampler_pkg::rejb_cnt_t cnt_q, cnt_d;
  mldsa_params_pkg::coeff_vec_t out_d;
  logic pop;

  // eta minus (n mod 5), negative results wrap to q - 1 and q - 2
  function automatic mldsa_params_pkg::coeff_t eta_map(
    input logic [sampler_pkg::REJB_SAMPLE_W-1:0] nib
  );
    logic [2:0] r;
    r = 3'(nib % 4'd5);
    if (r <= 3'(mldsa_params_pkg::MLDSA_ETA)) begin
      eta_map = mldsa_params_pkg::coeff_t'(mldsa_params_pkg::MLDSA_ETA) -
                mldsa_params_pkg::coeff_t'(r);
    end else begin
      eta_map = mldsa_params_pkg::MLDSA_Q +
                mldsa_params_pkg::coeff_t'(mldsa_params_pkg::MLDSA_ETA) -
                mldsa_params_pkg::coeff_t'(r);
    end
  endfunction

  assign pop = cnt_q >= sampler_pkg::rejb_cnt_t'(mldsa_params_pkg::COEFF_PER_CLK);

  // a full group of eight might not fit
  assign hold_o = cnt_q >= sampler_pkg::rejb_cnt_t'(sampler_pkg::REJB_HOLD_LEVEL);

  always_comb begin
    acc_d = acc_q;
    cnt_d = cnt_q;
    for (int l = 0; l < mldsa_params_pkg::COEFF_PER_CLK; l++) begin
      out_d[l] = acc_q[l];
    end
    if (pop) begin
      for (int i = 0; i < sampler_pkg::REJB_BUF_DEPTH - mldsa_params_pkg::COEFF_PER_CLK; i++) begin
        acc_d[i] = acc_q[i + mldsa_params_pkg::COEFF_PER_CLK];
      end
      cnt_d = cnt_q - sampler_pkg::rejb_cnt_t'(mldsa_params_pkg::COEFF_PER_CLK);
    end
    if (valid_i) begin
      for (int s = 0; s < sampler_pkg::REJB_NUM_SAMPLERS; s++) begin
        if (data_i[s] < sampler_pkg::REJB_VALUE) begin
          acc_d[cnt_d] = eta_map(data_i[s]);
          cnt_d = cnt_d + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q <= '0;
      valid_o <= 1'b0;
    end else if (clear_i) begin
      cnt_q <= '0;
      valid_o <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      valid_o <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (clear_i) begin
      acc_q <= '{default: '0};
      data_o <= '0;
    end else begin
      acc_q <= acc_d;
      if (pop) begin
        data_o <= out_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sampler_top.sv ====
/* sampler top, joins command control, PISO, uniform and
   bounded samplers and steers them by the command mode */
`default_nettype none

module sampler_top (
  input  logic                         clk,
  input  logic                         rst_b,
  input  logic                         zeroize_i,
  input  logic                         start_i,
  input  sampler_pkg::sampler_cmd_t    cmd_i,
  output logic                         squeeze_o,
  input  logic                         block_valid_i,
  input  sampler_pkg::block_t          block_i,
  output logic                         block_hold_o,
  output logic                         busy_o,
  output logic                         ntt_dv_o,
  output mldsa_params_pkg::coeff_vec_t ntt_data_o,
  output logic                         mem_dv_o,
  output mldsa_params_pkg::coeff_vec_t mem_data_o,
  output sampler_pkg::mem_addr_t       mem_addr_o
);

  logic mode_bounded;
  logic block_taken;
  logic clear;
  logic coeff_vld;
  logic piso_valid_in;
  logic piso_valid;
  logic piso_hold;
  logic rejb_hold;
  sampler_pkg::piso_data_t piso_data;

  assign mode_bounded = (cmd_i.mode == sampler_pkg::MODE_REJ_BOUNDED);

  assign block_taken = block_valid_i & ~block_hold_o;
  // blocks outside a run are dropped
  assign piso_valid_in = block_valid_i & busy_o & ~start_i;

  // only the bounded sampler back-pressures
  assign piso_hold = mode_bounded & rejb_hold;
  assign coeff_vld = mode_bounded ? mem_dv_o : ntt_dv_o;

  sampler_ctrl sampler_ctrl_inst (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .start_i      (start_i),
    .cmd_i        (cmd_i),
    .coeff_vld_i  (coeff_vld),
    .block_taken_i(block_taken),
    .squeeze_o    (squeeze_o),
    .busy_o       (busy_o),
    .clear_o      (clear),
    .dest_addr_o  (mem_addr_o)
  );

  sampler_piso sampler_piso_inst (
    .clk    (clk),
    .rst_b  (rst_b),
    .clear_i(clear),
    .mode_i (cmd_i.mode),
    .valid_i(piso_valid_in),
    .data_i (block_i),
    .hold_o (block_hold_o),
    .valid_o(piso_valid),
    .hold_i (piso_hold),
    .data_o (piso_data)
  );

  // uniform samples go to the NTT port
  rej_sampler rej_sampler_inst (
    .clk    (clk),
    .rst_b  (rst_b),
    .clear_i(clear),
    .valid_i(piso_valid & ~mode_bounded),
    .data_i (piso_data),
    .valid_o(ntt_dv_o),
    .data_o (ntt_data_o)
  );

  // bounded samples go to memory with the running address
  rej_bounded rej_bounded_inst (
    .clk    (clk),
    .rst_b  (rst_b),
    .clear_i(clear),
    .valid_i(piso_valid & mode_bounded),
    .data_i (piso_data[sampler_pkg::REJB_PISO_OUTPUT_RATE-1:0]),
    .hold_o (rejb_hold),
    .valid_o(mem_dv_o),
    .data_o (mem_data_o)
  );

endmodule

`default_nettype wire

// ==== dv/sampler_tb.sv ====
/* sampler testbench with block source model, reference model,
   output checks and report */
`default_nettype none

module sampler_tb;

  logic clk;
  logic rst_b;
  logic zeroize_i;
  logic start_i;
  sampler_pkg::sampler_cmd_t cmd_i;
  logic squeeze_o;
  logic block_valid_i;
  sampler_pkg::block_t block_i;
  logic block_hold_o;
  logic busy_o;
  logic ntt_dv_o;
  mldsa_params_pkg::coeff_vec_t ntt_data_o;
  logic mem_dv_o;
  mldsa_params_pkg::coeff_vec_t mem_data_o;
  sampler_pkg::mem_addr_t mem_addr_o;

  // test data columns and run state
  int t_mode[$], t_base[$], t_delay[$], t_rate[$], t_zero[$];
  int unsigned exp_q[$];
  int pend[$];
  int seed, cyc, limit, errors, checks;
  int outs, last_at, squeezes, delivered;
  int cmd_base, src_delay, src_rate;
  bit cmd_bounded, taken_next, hold_seen;
  bit s_busy, s_squeeze, s_hold, s_ntt_dv, s_mem_dv;

  sampler_top sampler_top_inst (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .start_i      (start_i),
    .cmd_i        (cmd_i),
    .squeeze_o    (squeeze_o),
    .block_valid_i(block_valid_i),
    .block_i      (block_i),
    .block_hold_o (block_hold_o),
    .busy_o       (busy_o),
    .ntt_dv_o     (ntt_dv_o),
    .ntt_data_o   (ntt_data_o),
    .mem_dv_o     (mem_dv_o),
    .mem_data_o   (mem_data_o),
    .mem_addr_o   (mem_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    wait (limit > 0);
    while (cyc < limit) @(posedge clk);
    $display("timeout: run stopped after %0d cycles", cyc);
    $display("Finished with errors");
    $finish;
  end

  task automatic check_cond(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("%s", msg);
      errors++;
    end
  endtask

  // random block with some samples pushed out of range at the given rate
  function automatic sampler_pkg::block_t make_block();
    sampler_pkg::block_t blk;
    blk = {$random(seed), $random(seed), $random(seed)};
    for (int s = 0; s < 4; s++) begin
      if (!cmd_bounded && ({$random(seed)} % 100) < src_rate) begin
        blk[24*s +: 23] = 23'(mldsa_params_pkg::MLDSA_Q + ({$random(seed)} % 8191));
      end
    end
    for (int n = 0; n < 24; n++) begin
      if (cmd_bounded && ({$random(seed)} % 100) < src_rate) begin
        blk[4*n +: 4] = 4'hf;
      end
    end
    return blk;
  endfunction

  // expected coefficients of one block in order from the lowest bits
  task automatic model_block(input sampler_pkg::block_t blk);
    int unsigned v;
    int c;
    if (!cmd_bounded) begin
      for (int s = 0; s < 4; s++) begin
        v = blk[24*s +: 23];
        if (v < mldsa_params_pkg::MLDSA_Q) exp_q.push_back(v);
      end
    end else begin
      for (int n = 0; n < 24; n++) begin
        v = blk[4*n +: 4];
        if (v < 15) begin
          c = 2 - int'(v % 5);
          if (c < 0) c = c + int'(mldsa_params_pkg::MLDSA_Q);
          exp_q.push_back(c);
        end
      end
    end
  endtask

  task automatic check_outputs();
    mldsa_params_pkg::coeff_vec_t exp_vec;
    sampler_pkg::mem_addr_t exp_addr;
    if (s_ntt_dv || s_mem_dv) begin
      check_cond(cmd_bounded ? !s_ntt_dv : !s_mem_dv, "output valid on the other mode's port");
      check_cond(outs < 64, "more than 64 output valid cycles in one command");
      check_cond(exp_q.size() >= 4, "output valid before 4 expected samples were available");
      exp_vec = '0;
      for (int l = 0; l < 4 && exp_q.size() > 0; l++) begin
        exp_vec[l] = mldsa_params_pkg::coeff_t'(exp_q.pop_front());
      end
      exp_addr = sampler_pkg::mem_addr_t'(cmd_base + outs);
      if (cmd_bounded) begin
        check_cond(mem_data_o == exp_vec, $sformatf("FAILED mem_data_o expected %h actual %h",
                                                    exp_vec, mem_data_o));
        check_cond(mem_addr_o == exp_addr, $sformatf("FAILED mem_addr_o expected %h actual %h",
                                                     exp_addr, mem_addr_o));
      end else begin
        check_cond(ntt_data_o == exp_vec, $sformatf("FAILED ntt_data_o expected %h actual %h",
                                                    exp_vec, ntt_data_o));
      end
      outs++;
      if (outs == 64) last_at = cyc;
    end
  endtask

  // block source that answers each squeeze after the delay
  task automatic drive_source(input bit start, input bit zero);
    if (zero) begin
      pend.delete();
      block_valid_i = 1'b0;
      taken_next = 1'b0;
    end else begin
      if (s_squeeze) begin
        squeezes++;
        pend.push_back(cyc + 1 + src_delay);
      end
      if (block_valid_i && taken_next) begin
        block_valid_i = 1'b0;
        delivered++;
      end
      if (!block_valid_i && pend.size() > 0 && pend[0] <= cyc) begin
        void'(pend.pop_front());
        block_i = make_block();
        block_valid_i = 1'b1;
      end
      // hold only moves on the rising edge, so this is the value it sees
      taken_next = block_valid_i && !s_hold;
      if (taken_next && s_busy && !start) model_block(block_i);
      check_cond(squeezes <= delivered + 1, "squeeze_o ran ahead of the delivered blocks");
    end
  endtask

  task automatic tick(input bit start, input bit zero);
    @(negedge clk);
    s_busy = busy_o;
    s_squeeze = squeeze_o;
    s_hold = block_hold_o;
    s_ntt_dv = ntt_dv_o;
    s_mem_dv = mem_dv_o;
    if (s_hold) hold_seen = 1'b1;
    start_i = start;
    zeroize_i = zero;
    check_outputs();
    drive_source(start, zero);
  endtask

  // one command that zeroize cuts short when zcyc is not 0
  task automatic run_cmd(input int zcyc);
    int n;
    exp_q.delete();
    outs = 0;
    last_at = 0;
    squeezes = 0;
    delivered = 0;
    cmd_i.mode = cmd_bounded ? sampler_pkg::MODE_REJ_BOUNDED : sampler_pkg::MODE_REJ_UNIFORM;
    cmd_i.dest_base_addr = sampler_pkg::mem_addr_t'(cmd_base);
    tick(1'b1, 1'b0);
    tick(1'b0, 1'b0);
    check_cond(s_squeeze, "no squeeze_o one cycle after start_i");
    n = 2;
    while (s_busy && !(zcyc != 0 && n >= zcyc)) begin
      tick(1'b0, 1'b0);
      n++;
    end
    if (zcyc != 0) begin
      tick(1'b0, 1'b1);
      tick(1'b0, 1'b0);
      check_cond(!(s_busy | s_squeeze | s_ntt_dv | s_mem_dv | s_hold),
                 "busy, squeeze, hold or a valid still high after zeroize");
    end else begin
      check_cond(outs == 64, $sformatf("FAILED output valid count expected %h actual %h",
                                       64, outs));
      check_cond(cyc - last_at <= 3,
                 "busy_o stayed high more than 3 cycles after the last output");
      while (pend.size() > 0 || block_valid_i) tick(1'b0, 1'b0);
      repeat (3) tick(1'b0, 1'b0);
    end
  endtask

  initial begin
    int fd;
    int code;
    int m, b, d, r, z;
    int err0;
    string line;
    seed = 32'hc0e0;
    limit = 0;
    errors = 0;
    checks = 0;
    rst_b = 1'b0;
    zeroize_i = 1'b0;
    start_i = 1'b0;
    cmd_i = '0;
    block_valid_i = 1'b0;
    block_i = '0;
    taken_next = 1'b0;
    fd = $fopen("dv/sampler_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file dv/sampler_testdata.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && $sscanf(line, "%d %h %d %d %d", m, b, d, r, z) == 5) begin
          t_mode.push_back(m);
          t_base.push_back(b);
          t_delay.push_back(d);
          t_rate.push_back(r);
          t_zero.push_back(z);
        end
      end
      $fclose(fd);
    end
    for (int t = 0; t < t_mode.size(); t++) begin
      limit = limit + 64 * (t_delay[t] + 4) + 200 + t_zero[t];
    end
    repeat (5) @(negedge clk);
    rst_b = 1'b1;
    tick(1'b0, 1'b0);
    check_cond(!s_busy && !s_squeeze, "busy_o or squeeze_o high after reset");
    for (int t = 0; t < t_mode.size(); t++) begin
      err0 = errors;
      cmd_bounded = (t_mode[t] != 0);
      cmd_base = t_base[t];
      src_delay = t_delay[t];
      src_rate = t_rate[t];
      hold_seen = 1'b0;
      if (t_zero[t] != 0) run_cmd(t_zero[t]);
      run_cmd(0);
      if (cmd_bounded && src_delay == 0 && src_rate == 0) begin
        check_cond(hold_seen, "block_hold_o never rose with back to back blocks");
      end
      $display("test %0d %s base %h delay %0d reject %0d zeroize %0d: %0d errors", t,
               cmd_bounded ? "bounded" : "uniform", cmd_base, src_delay, src_rate,
               t_zero[t], errors - err0);
    end
    $display("tests %0d, checks %0d, errors %0d", t_mode.size(), checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/sampler_testdata.txt ====
# mode (0 uniform, 1 bounded), base address (hex), source delay, reject percent, zeroize cycle
# zeroize cycle counts from start_i, 0 runs the command to the end
0 000 0 0 0
0 100 2 10 0
0 200 5 15 0
1 300 0 0 0
1 3f0 1 15 0
1 ffc 3 30 0
0 040 1 5 30
1 080 0 10 45

// ==== tb.f ====
rtl/mldsa_params_pkg.sv
rtl/sampler_pkg.sv
rtl/sampler_ctrl.sv
rtl/sampler_piso.sv
rtl/rej_sampler.sv
rtl/rej_bounded.sv
rtl/sampler_top.sv
dv/sampler_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sampler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module sampler_tb -f tb.f -o sampler_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sampler_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation passed"
exit 0
